//--- hdl/flow_settings.svh
`ifndef FLOW_SETTINGS_SVH
`define FLOW_SETTINGS_SVH

// Datapath geometry
`define WORD_BITS     16
`define REG_IDX_BITS  4
`define OPC_BITS      5
`define REG_COUNT     10

// Special registers after R0..R7
`define REG_T         4'd8
`define REG_RA        4'd9

// Major opcodes, insn[15:11]
`define OPC_B         5'b00010
`define OPC_BEQZ      5'b00100
`define OPC_BNEZ      5'b00101
`define OPC_BT        5'b01100
`define OPC_LI        5'b01101
`define OPC_CMPI      5'b01110
`define OPC_JR        5'b11101

// Jump-register group, insn[7:0]
`define FN_JR         8'b00000000
`define FN_JALR       8'b11000000
`define FN_JRRA       8'b00100000

// T-register branches, insn[10:8]
`define BT_EQ         3'b000
`define BT_NE         3'b001

`endif

//--- hdl/flow_pkg.sv
`include "flow_settings.svh"

package flow_pkg;

	// Register values, PCs and instruction words
	typedef logic [`WORD_BITS-1:0] word_t;

	// R0..R7, T and RA
	typedef logic [`REG_IDX_BITS-1:0] reg_idx_t;

	// Major opcode field
	typedef logic [`OPC_BITS-1:0] opcode_t;

	// Decoded operation kind, anything unknown maps to OP_NOP
	typedef enum logic [3:0] {
		OP_NOP,
		OP_LI,
		OP_CMPI,
		OP_B,
		OP_BEQZ,
		OP_BNEZ,
		OP_BTEQZ,
		OP_BTNEZ,
		OP_JR,
		OP_JALR,
		OP_JRRA
	} op_kind_t;

endpackage

//--- hdl/flow_if.sv
// Decoded instruction handed from decode to execute
interface decode_bus;
	import flow_pkg::*;

	op_kind_t kind;
	word_t    op1;     // Selected source register value
	word_t    pc_cur;
	word_t    offset;  // Sign-extended branch offset
	word_t    imm;
	reg_idx_t dest;

	modport source (
		output kind,
		output op1,
		output pc_cur,
		output offset,
		output imm,
		output dest
	);

	modport sink (
		input kind,
		input op1,
		input pc_cur,
		input offset,
		input imm,
		input dest
	);
endinterface

// PC update and register write request
interface result_bus;
	import flow_pkg::*;

	logic     set_pc;
	word_t    target;
	logic     write_reg;
	reg_idx_t write_idx;
	word_t    write_value;

	modport source (
		output set_pc,
		output target,
		output write_reg,
		output write_idx,
		output write_value
	);

	modport sink (
		input set_pc,
		input target,
		input write_reg,
		input write_idx,
		input write_value
	);
endinterface

//--- hdl/insn_decode.sv
`include "flow_settings.svh"

module insn_decode (
	input  flow_pkg::word_t    insn,
	input  flow_pkg::word_t    pc,
	input  flow_pkg::word_t    rd_value,
	output flow_pkg::reg_idx_t rd_idx,
	decode_bus.source          dec
);
	import flow_pkg::*;

	opcode_t    opcode;
	logic [2:0] rx;
	logic [7:0] funct;
	reg_idx_t   rx_idx;
	op_kind_t   kind;
	word_t      off_long;
	word_t      off_short;
	word_t      imm_zext;
	reg_idx_t   src_idx;
	reg_idx_t   dest_idx;

	// Instruction fields
	assign opcode = insn[15:11];
	assign rx     = insn[10:8];
	assign funct  = insn[7:0];
	assign rx_idx = {1'b0, rx};

	// B carries 11 bits, the others 8
	assign off_long  = {{(`WORD_BITS-11){insn[10]}}, insn[10:0]};
	assign off_short = {{(`WORD_BITS-8){insn[7]}}, insn[7:0]};
	assign imm_zext  = {{(`WORD_BITS-8){1'b0}}, insn[7:0]};

	// Operation kind
	always_comb begin
		kind = OP_NOP;
		case (opcode)
			`OPC_B:    kind = OP_B;
			`OPC_BEQZ: kind = OP_BEQZ;
			`OPC_BNEZ: kind = OP_BNEZ;
			`OPC_LI:   kind = OP_LI;
			`OPC_CMPI: kind = OP_CMPI;
			`OPC_BT: begin
				if (rx == `BT_EQ) begin
					kind = OP_BTEQZ;
				end else if (rx == `BT_NE) begin
					kind = OP_BTNEZ;
				end
			end
			`OPC_JR: begin
				if (funct == `FN_JR) begin
					kind = OP_JR;
				end else if (funct == `FN_JALR) begin
					kind = OP_JALR;
				end else if (funct == `FN_JRRA && rx == 3'b000) begin
					kind = OP_JRRA;
				end
			end
			default: kind = OP_NOP;
		endcase
	end

	// Source register for op1
	always_comb begin
		case (kind)
			OP_BTEQZ, OP_BTNEZ: src_idx = `REG_T;
			OP_JRRA:            src_idx = `REG_RA;
			default:            src_idx = rx_idx; // BEQZ, BNEZ, JR, JALR, CMPI
		endcase
	end

	// Destination register
	always_comb begin
		case (kind)
			OP_CMPI: dest_idx = `REG_T;
			OP_JALR: dest_idx = `REG_RA;
			default: dest_idx = rx_idx; // LI
		endcase
	end

	assign rd_idx = src_idx;

	assign dec.kind   = kind;
	assign dec.op1    = rd_value;
	assign dec.pc_cur = pc;
	assign dec.offset = (kind == OP_B) ? off_long : off_short;
	assign dec.imm    = (kind == OP_LI) ? imm_zext : off_short; // CMPI is signed
	assign dec.dest   = dest_idx;
endmodule

//--- hdl/jump_execute.sv
module jump_execute (
	decode_bus.sink   dec,
	result_bus.source res
);
	import flow_pkg::*;

	word_t    rel_target;
	word_t    link_value;
	logic     op1_zero;
	logic     taken;
	word_t    target;
	logic     write_reg;
	word_t    write_value;

	assign rel_target = dec.pc_cur + dec.offset + word_t'(1);
	assign link_value = dec.pc_cur + word_t'(1);
	assign op1_zero   = (dec.op1 == '0);

	// Branch decision
	always_comb begin
		case (dec.kind)
			OP_B:     taken = 1'b1;
			OP_BEQZ:  taken = op1_zero;
			OP_BNEZ:  taken = !op1_zero;
			OP_BTEQZ: taken = op1_zero;  // op1 holds T here
			OP_BTNEZ: taken = !op1_zero;
			OP_JR:    taken = 1'b1;
			OP_JALR:  taken = 1'b1;
			OP_JRRA:  taken = 1'b1;
			default:  taken = 1'b0;
		endcase
	end

	// Target address
	always_comb begin
		case (dec.kind)
			OP_JR, OP_JALR, OP_JRRA: target = dec.op1;
			default:                 target = rel_target;
		endcase
	end

	// Register write request
	always_comb begin
		write_reg   = 1'b0;
		write_value = '0;
		case (dec.kind)
			OP_LI: begin
				write_reg   = 1'b1;
				write_value = dec.imm;
			end
			OP_CMPI: begin
				write_reg   = 1'b1;
				write_value = (dec.op1 == dec.imm) ? word_t'(0) : word_t'(1);
			end
			OP_JALR: begin
				write_reg   = 1'b1;
				write_value = link_value; // Return address
			end
			default: begin
				write_reg   = 1'b0;
				write_value = '0;
			end
		endcase
	end

	assign res.set_pc      = taken;
	assign res.target      = target;
	assign res.write_reg   = write_reg;
	assign res.write_idx   = dec.dest;
	assign res.write_value = write_value;
endmodule

//--- hdl/pc_result.sv
`include "flow_settings.svh"

module pc_result (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  flow_pkg::reg_idx_t rd_idx,
	output flow_pkg::word_t    rd_value,
	output flow_pkg::word_t    pc,
	output logic               wb_en,
	output flow_pkg::reg_idx_t wb_idx,
	output flow_pkg::word_t    wb_value,
	result_bus.sink            res
);
	import flow_pkg::*;

	word_t regs [`REG_COUNT];
	word_t pc_q;
	word_t pc_next;
	logic  write_ok;
	logic  commit;

	// Writes beyond RA are dropped
	assign write_ok = res.write_reg && (res.write_idx < reg_idx_t'(`REG_COUNT));
	assign commit   = run && write_ok;
	assign pc_next  = res.set_pc ? res.target : pc_q + word_t'(1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else if (run) begin
			pc_q <= pc_next;
		end
	end

	// Architectural registers R0..R7, T, RA
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit) begin
			regs[res.write_idx] <= res.write_value;
		end
	end

	// Writeback trace
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_en <= 1'b0;
		end else begin
			wb_en <= commit;
		end
	end

	always_ff @(posedge clk) begin
		if (commit) begin
			wb_idx   <= res.write_idx;
			wb_value <= res.write_value;
		end
	end

	// Combinational read port
	always_comb begin
		if (rd_idx < reg_idx_t'(`REG_COUNT)) begin
			rd_value = regs[rd_idx];
		end else begin
			rd_value = '0;
		end
	end

	assign pc = pc_q;
endmodule

//--- hdl/flow_core.sv
module flow_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,
	input  flow_pkg::word_t    insn,     // Word at address pc
	output flow_pkg::word_t    pc,
	output logic               wb_en,
	output flow_pkg::reg_idx_t wb_idx,
	output flow_pkg::word_t    wb_value
);
	import flow_pkg::*;

	reg_idx_t rd_idx;
	word_t    rd_value;

	decode_bus dec_bus ();
	result_bus res_bus ();

	insn_decode u_decode (
		.insn     (insn),
		.pc       (pc),
		.rd_value (rd_value),
		.rd_idx   (rd_idx),
		.dec      (dec_bus.source)
	);

	jump_execute u_execute (
		.dec (dec_bus.sink),
		.res (res_bus.source)
	);

	pc_result u_result (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.rd_idx   (rd_idx),
		.rd_value (rd_value),
		.pc       (pc),
		.wb_en    (wb_en),
		.wb_idx   (wb_idx),
		.wb_value (wb_value),
		.res      (res_bus.sink)
	);
endmodule

//--- test/flow_core_tb.sv
`include "flow_settings.svh"

module flow_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import flow_pkg::*;

	localparam int RESET_CYCLES   = 3;
	localparam int RUN_CYCLES     = 1200;
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + RESET_CYCLES + 97;

	logic     clk;
	logic     rst_n;
	logic     run;
	word_t    insn;
	word_t    pc;
	logic     wb_en;
	reg_idx_t wb_idx;
	word_t    wb_value;

	word_t       prog [256];  // Indexed by pc[7:0]
	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	int          cycle_count;

	// Reference model state
	word_t    m_pc;
	word_t    m_regs [`REG_COUNT];
	logic     exp_wb_en;
	reg_idx_t exp_wb_idx;
	word_t    exp_wb_value;

	assign insn = prog[pc[7:0]];

	flow_core flow_core_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.run      (run),
		.insn     (insn),
		.pc       (pc),
		.wb_en    (wb_en),
		.wb_idx   (wb_idx),
		.wb_value (wb_value)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	function automatic word_t make_insn();
		word_t      r;
		word_t      w;
		logic [2:0] rx;
		logic [7:0] imm;
		int         sel;
		r   = lcg_next();
		rx  = r[10:8];
		imm = r[15] ? {6'b0, r[1:0]} : r[7:0];  // Small values hit zero and CMPI equality
		if (imm == 8'hff) begin
			imm = 8'h01;  // No single-instruction loops
		end
		sel = int'(lcg_next() % 16'd12);
		case (sel)
			0, 1: w = {`OPC_LI, rx, imm};
			2:    w = {`OPC_CMPI, rx, imm};
			3:    w = {`OPC_B, rx, imm};
			4:    w = {`OPC_BEQZ, rx, imm};
			5:    w = {`OPC_BNEZ, rx, imm};
			6:    w = {`OPC_BT, `BT_EQ, imm};
			7:    w = {`OPC_BT, `BT_NE, imm};
			8:    w = {`OPC_JR, rx, `FN_JR};
			9:    w = {`OPC_JR, rx, `FN_JALR};
			10:   w = {`OPC_JR, 3'b000, `FN_JRRA};
			default: w = lcg_next();  // Junk
		endcase
		return w;
	endfunction

	// One architectural step of the model with the run value seen at this edge
	task automatic model_step();
		word_t      w;
		logic [2:0] rx;
		word_t      src;
		word_t      short_off;
		word_t      long_off;
		word_t      next_pc;
		logic       we;
		reg_idx_t   widx;
		word_t      wval;
		w         = prog[m_pc[7:0]];
		rx        = w[10:8];
		src       = m_regs[rx];
		short_off = {{8{w[7]}}, w[7:0]};
		long_off  = {{5{w[10]}}, w[10:0]};
		next_pc   = m_pc + 16'd1;
		we        = 1'b0;
		widx      = '0;
		wval      = '0;
		case (w[15:11])
			`OPC_LI: begin
				we   = 1'b1;
				widx = {1'b0, rx};
				wval = {8'h00, w[7:0]};
			end
			`OPC_CMPI: begin
				we   = 1'b1;
				widx = `REG_T;
				wval = (src == short_off) ? 16'd0 : 16'd1;
			end
			`OPC_B: next_pc = m_pc + long_off + 16'd1;
			`OPC_BEQZ: if (src == 16'd0) next_pc = m_pc + short_off + 16'd1;
			`OPC_BNEZ: if (src != 16'd0) next_pc = m_pc + short_off + 16'd1;
			`OPC_BT: begin
				if ((rx == `BT_EQ && m_regs[`REG_T] == 16'd0) ||
						(rx == `BT_NE && m_regs[`REG_T] != 16'd0)) begin
					next_pc = m_pc + short_off + 16'd1;
				end
			end
			`OPC_JR: begin
				if (w[7:0] == `FN_JR) begin
					next_pc = src;
				end else if (w[7:0] == `FN_JALR) begin
					next_pc = src;
					we      = 1'b1;
					widx    = `REG_RA;
					wval    = m_pc + 16'd1;
				end else if (w[7:0] == `FN_JRRA && rx == 3'b000) begin
					next_pc = m_regs[`REG_RA];
				end
			end
			default: ;  // NOP and unknown encodings
		endcase
		exp_wb_en = run && we;
		if (run) begin
			m_pc = next_pc;
			if (we) begin
				m_regs[widx] = wval;
			end
			exp_wb_idx   = widx;
			exp_wb_value = wval;
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_write(input reg_idx_t exp_idx, input word_t exp_value);
		checks++;
		if (wb_en !== 1'b1) begin
			errors++;
			$display("mismatch at %0t: wb_en got %b expected 1", $time, wb_en);
		end else if (wb_idx !== exp_idx) begin
			errors++;
			$display("mismatch at %0t: wb_idx got %0d expected %0d", $time, wb_idx, exp_idx);
		end else begin
			check_word("wb_value", wb_value, exp_value);
		end
	endtask

	task automatic check_idle();
		checks++;
		if (wb_en !== 1'b0) begin
			errors++;
			$display("mismatch at %0t: wb_en got %b expected 0", $time, wb_en);
		end
	endtask

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the test loop never finished", cycle_count);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin : stimulus
		logic [7:0] addr;
		lcg_state = 32'h84ca;
		checks    = 0;
		errors    = 0;
		rst_n     = 1'b0;
		run       = 1'b0;
		m_pc      = '0;
		exp_wb_en = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			m_regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			prog[i] = make_insn();
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_word("pc", pc, word_t'(0));
		check_idle();
		for (int c = 0; c < RUN_CYCLES; c++) begin
			@(posedge clk);
			model_step();
			addr = 8'(lcg_next() >> 8);
			prog[addr] <= make_insn();  // Mutation breaks long loops
			run <= (lcg_next() % 16'd10) < 16'd8;
			@(negedge clk);
			check_word("pc", pc, m_pc);
			if (exp_wb_en) begin
				check_write(exp_wb_idx, exp_wb_value);
			end else begin
				check_idle();
			end
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end
endmodule

//--- flow_core.f
+incdir+hdl
hdl/flow_pkg.sv
hdl/flow_if.sv
hdl/insn_decode.sv
hdl/jump_execute.sv
hdl/pc_result.sv
hdl/flow_core.sv
test/flow_core_tb.sv

//--- Makefile
TOP = flow_core_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flow_core.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log
